/* flist.f */
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/sync_ram.sv
hdl/regfile.sv
hdl/imm_gen.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/forwarding_unit.sv
hdl/riscv_core.sv
dv/riscv_core_assert.sv
dv/tb_riscv_core.sv

/* dv/tb_riscv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_core;

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;

    localparam logic [31:0] IO_ADDR = 32'h8000_0010; // csr output word
    localparam logic [2:0]  BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic            clk;
    logic            arst_n;
    logic            imem_load_we;
    logic [9:0]      imem_load_addr;
    core_pkg::word_t imem_load_data;
    core_pkg::word_t csr;
    logic            csr_valid;

    // program table: words and expected csr values, sliced per entry
    core_pkg::word_t prog_q [$];
    core_pkg::word_t exp_q [$];
    int              entry_first [$];
    int              entry_len [$];
    int              exp_first [$];
    int              exp_len [$];
    string           entry_name [$];

    logic [31:0] rng_state      = 32'h2caa;
    int          cycle_count    = 0;
    int          timeout_cycles = 200;

    riscv_core riscv_core_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .imem_load_we   (imem_load_we),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .csr            (csr),
        .csr_valid      (csr_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the csr writes did not all arrive within %0d cycles",
                     timeout_cycles);
            $display("Result: FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function core_pkg::word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // lcg
        return rng_state;
    endfunction

    function automatic core_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic core_pkg::word_t enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // sw
    endfunction

    function automatic core_pkg::word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
    endfunction

    function automatic core_pkg::word_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic core_pkg::word_t enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic core_pkg::word_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return enc_i(OP_IMM, 3'b000, rd, rs1, imm);
    endfunction

    // x31 holds the upper part of IO_ADDR in every program
    function automatic core_pkg::word_t store_io(input logic [4:0] rs2);
        return enc_s(5'd31, rs2, IO_ADDR[11:0]);
    endfunction

    function automatic core_pkg::word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input core_pkg::word_t a,
                                        input core_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic core_pkg::word_t here_pc();
        return 4 * (prog_q.size() - entry_first[$]); // byte address of the next word
    endfunction

    task automatic emit(input core_pkg::word_t w);
        prog_q.push_back(w);
    endtask

    task automatic expect_csr(input core_pkg::word_t v);
        exp_q.push_back(v);
    endtask

    task automatic start_entry(input string name);
        entry_name.push_back(name);
        entry_first.push_back(prog_q.size());
        exp_first.push_back(exp_q.size());
        emit(enc_u(OP_LUI, 5'd31, IO_ADDR[31:12]));
    endtask

    task automatic end_entry();
        emit(enc_j(5'd0, 21'd0)); // spin here
        entry_len.push_back(prog_q.size() - entry_first[$]);
        exp_len.push_back(exp_q.size() - exp_first[$]);
    endtask

    task automatic build_alu_chain();
        core_pkg::word_t rnd;
        core_pkg::word_t v [7];
        rnd = next_rand();
        v[1] = sext12(rnd[27:16]);
        rnd = next_rand();
        v[2] = sext12(rnd[27:16]);
        v[3] = v[1] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] ^ v[3];
        v[6] = $signed(v[5]) >>> v[2][4:0];
        start_entry("alu chain");
        emit(addi(5'd1, 5'd0, v[1][11:0]));
        emit(addi(5'd2, 5'd0, v[2][11:0]));
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2)); // add
        emit(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1)); // sub
        emit(enc_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd3)); // xor
        emit(enc_r(7'h20, 3'b101, 5'd6, 5'd5, 5'd2)); // sra
        for (int k = 3; k <= 6; k++) begin
            emit(store_io(k[4:0]));
            expect_csr(v[k]);
            if (k < 6) begin
                emit(addi(5'd0, 5'd0, 12'd0)); // keeps csr stores apart
            end
        end
        end_entry();
    endtask

    task automatic build_upper_imm();
        core_pkg::word_t rnd;
        core_pkg::word_t pc;
        start_entry("lui auipc");
        rnd = next_rand();
        emit(enc_u(OP_LUI, 5'd1, rnd[31:12]));
        expect_csr({rnd[31:12], 12'b0});
        rnd = next_rand();
        pc  = here_pc();
        emit(enc_u(OP_AUIPC, 5'd2, rnd[19:0]));
        expect_csr(pc + {rnd[19:0], 12'b0});
        emit(store_io(5'd1));
        emit(addi(5'd0, 5'd0, 12'd0));
        emit(store_io(5'd2));
        end_entry();
    endtask

    task automatic build_load_store();
        core_pkg::word_t rnd;
        start_entry("load store");
        rnd = next_rand();
        emit(addi(5'd1, 5'd0, rnd[27:16]));
        emit(addi(5'd2, 5'd0, 12'h040)); // dmem word 16
        emit(addi(5'd5, 5'd0, rnd[11:0]));
        emit(enc_s(5'd2, 5'd1, 12'd0));
        emit(enc_i(OP_LOAD, 3'b010, 5'd3, 5'd2, 12'd0));
        emit(enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd5)); // uses the load result at once
        emit(store_io(5'd4));
        expect_csr(sext12(rnd[27:16]) + sext12(rnd[11:0]));
        end_entry();
    endtask

    task automatic build_branches(input string name, input int first_kind);
        core_pkg::word_t rv [4];
        logic [2:0]      f3;
        logic [4:0]      ra;
        logic [4:0]      rb;
        logic [4:0]      rm;
        rv[0] = '0;
        rv[1] = 32'hffff_fffb;
        rv[2] = 32'd3;
        rv[3] = 32'd3;
        start_entry(name);
        emit(addi(5'd1, 5'd0, 12'hffb));
        emit(addi(5'd2, 5'd0, 12'd3));
        emit(addi(5'd3, 5'd0, 12'd3));
        for (int k = first_kind; k < first_kind + 2; k++) begin
            for (int c = 0; c < 2; c++) begin
                f3 = BR_F3[k];
                if (f3[2]) begin // ordered compares, swap operands
                    ra = (c == 0) ? 5'd1 : 5'd2;
                    rb = (c == 0) ? 5'd2 : 5'd1;
                end else begin
                    ra = (c == 0) ? 5'd2 : 5'd1;
                    rb = (c == 0) ? 5'd3 : 5'd2;
                end
                rm = (c == 0) ? 5'd1 : 5'd2;
                emit(enc_b(f3, ra, rb, 13'd8)); // over the marker store
                emit(store_io(rm));
                if (!branch_ref(f3, rv[ra], rv[rb])) begin
                    expect_csr(rv[rm]);
                end
            end
        end
        end_entry();
    endtask

    task automatic build_jumps();
        core_pkg::word_t pc;
        core_pkg::word_t tgt;
        start_entry("jal jalr");
        pc = here_pc();
        emit(enc_j(5'd1, 21'd12));
        emit(store_io(5'd31)); // skipped
        emit(store_io(5'd31));
        emit(store_io(5'd1));
        expect_csr(pc + 32'd4);
        pc  = here_pc();
        tgt = pc + 32'd17; // odd on purpose, jalr drops bit 0
        emit(addi(5'd2, 5'd0, tgt[11:0]));
        emit(enc_i(OP_JALR, 3'b000, 5'd3, 5'd2, 12'd0));
        emit(store_io(5'd31));
        emit(store_io(5'd31));
        emit(store_io(5'd3)); // lands at pc + 16
        expect_csr(pc + 32'd8);
        emit(addi(5'd4, 5'd3, 12'd100));
        emit(store_io(5'd4));
        expect_csr(pc + 32'd108);
        end_entry();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, want);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic run_entry(input int e);
        int n;
        int reset_cycles;
        reset_cycles = (entry_len[e] + 1 > 16) ? entry_len[e] + 1 : 16;
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            arst_n <= 1'b0;
            if (i < entry_len[e]) begin
                imem_load_we   <= 1'b1;
                imem_load_addr <= i[9:0];
                imem_load_data <= prog_q[entry_first[e] + i];
            end else begin
                imem_load_we <= 1'b0;
            end
        end
        @(posedge clk);
        arst_n       <= 1'b1;
        imem_load_we <= 1'b0;
        n = 0;
        while (n < exp_len[e]) begin
            @(negedge clk); // outputs settled since the rising edge
            if (csr_valid) begin
                check_value($sformatf("%s csr write %0d", entry_name[e], n), csr,
                            exp_q[exp_first[e] + n]);
                n++;
            end
        end
        repeat (8) begin
            @(negedge clk);
            check_value($sformatf("%s csr_valid after the last write", entry_name[e]),
                        {31'b0, csr_valid}, 32'd0);
        end
        $display("%0t ns: %s done, %0d csr writes", $time, entry_name[e], n);
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        imem_load_we   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        build_alu_chain();
        build_upper_imm();
        build_load_store();
        build_branches("branch eq ne", 0);
        build_branches("branch lt ge", 2);
        build_branches("branch ltu geu", 4);
        build_jumps();
        timeout_cycles = 200 * entry_name.size();
        for (int e = 0; e < entry_name.size(); e++) begin
            run_entry(e);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/riscv_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_core_assert (
    input logic              clk,
    input logic              arst_n,
    input core_pkg::word_t   pc,
    input logic              csr_valid,
    input logic              redirect,
    input core_pkg::ex_reg_t ex_reg
);

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // pipeline still empty for three cycles after reset
    csr_quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !csr_valid [*3])
        else $error("csr_valid high before any store could execute");

    // one store per csr pulse
    csr_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        csr_valid |=> !csr_valid)
        else $error("csr_valid high for two cycles in a row");

    // decode slot and the fetch in flight are both killed
    flush_after_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !ex_reg.valid ##1 !ex_reg.valid)
        else $error("instruction after a redirect reached execute");

endmodule

bind riscv_core riscv_core_assert riscv_core_assert_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc        (pc),
    .csr_valid (csr_valid),
    .redirect  (redirect),
    .ex_reg    (ex_reg)
);

`default_nettype wire

/* hdl/riscv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_core #(
    parameter int              IMEM_AWIDTH = 10,
    parameter int              DMEM_AWIDTH = 10,
    parameter core_pkg::word_t RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   imem_load_we,
    input  logic [IMEM_AWIDTH-1:0] imem_load_addr, // word address
    input  core_pkg::word_t        imem_load_data,
    output core_pkg::word_t        csr,
    output logic                   csr_valid
);

    core_pkg::word_t        pc;
    core_pkg::word_t        pc_next;
    core_pkg::word_t        if_pc;    // address of the word leaving imem
    logic                   if_valid;
    logic [IMEM_AWIDTH-1:0] imem_addr;
    core_pkg::word_t        inst;

    core_pkg::ctrl_t        dec_ctrl;
    core_pkg::word_t        dec_imm;
    core_pkg::word_t        rf_rd1;
    core_pkg::word_t        rf_rd2;
    core_pkg::ex_reg_t      ex_d;
    core_pkg::ex_reg_t      ex_reg;

    core_pkg::word_t        op1;
    core_pkg::word_t        op2;
    core_pkg::word_t        alu_a;
    core_pkg::word_t        alu_b;
    core_pkg::word_t        alu_result;
    logic                   branch_taken;
    logic                   redirect;
    core_pkg::word_t        redirect_target;
    logic                   csr_hit;
    logic [DMEM_AWIDTH-1:0] dmem_addr;
    logic [3:0]             dmem_be;
    core_pkg::word_t        dmem_rdata;

    core_pkg::wb_reg_t      wb_d;
    core_pkg::wb_reg_t      wb_reg;
    core_pkg::word_t        wb_data;

    // fetch
    assign pc_next   = redirect ? redirect_target : pc + 32'd4;
    assign imem_addr = imem_load_we ? imem_load_addr : pc[IMEM_AWIDTH+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else begin
            pc       <= pc_next;
            if_valid <= !redirect; // kill the fetch in flight
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

    sync_ram #(.AWIDTH(IMEM_AWIDTH)) imem (
        .clk   (clk),
        .addr  (imem_addr),
        .wdata (imem_load_data),
        .be    ({4{imem_load_we}}),
        .rdata (inst)
    );

    // decode
    control_unit control_unit_inst (.inst(inst), .ctrl(dec_ctrl));
    imm_gen      imm_gen_inst      (.inst(inst), .imm(dec_imm));

    regfile rf (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (inst[19:15]),
        .ra2    (inst[24:20]),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2),
        .we     (wb_reg.valid && wb_reg.reg_write),
        .wa     (wb_reg.rd),
        .wd     (wb_data)
    );

    always_comb begin
        ex_d          = '0;
        ex_d.valid    = if_valid && !redirect;
        ex_d.pc       = if_pc;
        ex_d.rs1_data = rf_rd1;
        ex_d.rs2_data = rf_rd2;
        ex_d.rs1      = inst[19:15];
        ex_d.rs2      = inst[24:20];
        ex_d.rd       = inst[11:7];
        ex_d.imm      = dec_imm;
        ex_d.funct3   = inst[14:12];
        ex_d.ctrl     = dec_ctrl;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_reg <= '0;
        end else begin
            ex_reg <= ex_d;
        end
    end

    // execute
    forwarding_unit forwarding_unit_inst (
        .ex      (ex_reg),
        .wb      (wb_reg),
        .wb_data (wb_data),
        .op1     (op1),
        .op2     (op2)
    );

    always_comb begin
        case (ex_reg.ctrl.op_a_sel)
            core_pkg::OPA_PC:   alu_a = ex_reg.pc;
            core_pkg::OPA_ZERO: alu_a = '0;
            default:            alu_a = op1;
        endcase
    end

    assign alu_b = ex_reg.ctrl.use_imm ? ex_reg.imm : op2;

    alu alu_inst (
        .op           (ex_reg.ctrl.alu_op),
        .a            (alu_a),
        .b            (alu_b),
        .funct3       (ex_reg.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    assign redirect = ex_reg.valid &&
                      (ex_reg.ctrl.jump || (ex_reg.ctrl.branch && branch_taken));
    assign redirect_target = ex_reg.ctrl.jalr ? {alu_result[31:1], 1'b0}
                                              : ex_reg.pc + ex_reg.imm;

    // stores to the csr address never reach dmem
    assign csr_hit   = ex_reg.valid && ex_reg.ctrl.mem_write && (alu_result == core_pkg::CSR_ADDR);
    assign dmem_be   = (ex_reg.valid && ex_reg.ctrl.mem_write && !csr_hit) ? 4'hf : 4'h0;
    assign dmem_addr = (ex_reg.ctrl.mem_read || ex_reg.ctrl.mem_write)
                       ? alu_result[DMEM_AWIDTH+1:2] : '0; // idle at zero otherwise

    sync_ram #(.AWIDTH(DMEM_AWIDTH)) dmem (
        .clk   (clk),
        .addr  (dmem_addr),
        .wdata (op2),
        .be    (dmem_be),
        .rdata (dmem_rdata)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr       <= '0;
            csr_valid <= 1'b0;
        end else begin
            csr_valid <= csr_hit;
            if (csr_hit) begin
                csr <= op2;
            end
        end
    end

    always_comb begin
        wb_d            = '0;
        wb_d.valid      = ex_reg.valid;
        wb_d.rd         = ex_reg.rd;
        wb_d.reg_write  = ex_reg.ctrl.reg_write;
        wb_d.wb_sel     = ex_reg.ctrl.wb_sel;
        wb_d.alu_result = alu_result;
        wb_d.pc_plus4   = ex_reg.pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_reg <= '0;
        end else begin
            wb_reg <= wb_d;
        end
    end

    // write-back, load data arrives from dmem this cycle
    always_comb begin
        case (wb_reg.wb_sel)
            core_pkg::WB_MEM:      wb_data = dmem_rdata;
            core_pkg::WB_PC_PLUS4: wb_data = wb_reg.pc_plus4;
            default:               wb_data = wb_reg.alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/forwarding_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit (
    input  core_pkg::ex_reg_t ex,
    input  core_pkg::wb_reg_t wb,
    input  core_pkg::word_t   wb_data,
    output core_pkg::word_t   op1,
    output core_pkg::word_t   op2
);

    logic wb_live;
    logic fwd1;
    logic fwd2;

    // a write-back that really lands in the regfile
    assign wb_live = wb.valid && wb.reg_write && (wb.rd != '0);

    assign fwd1 = wb_live && (wb.rd == ex.rs1);
    assign fwd2 = wb_live && (wb.rd == ex.rs2);

    assign op1 = fwd1 ? wb_data : ex.rs1_data;
    assign op2 = fwd2 ? wb_data : ex.rs2_data;

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  core_pkg::alu_op_t   op,
    input  core_pkg::word_t     a,
    input  core_pkg::word_t     b,
    input  rv_isa_pkg::funct3_t funct3,
    output core_pkg::word_t     result,
    output logic                branch_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            core_pkg::ALU_ADD:  result = a + b;
            core_pkg::ALU_SUB:  result = a - b;
            core_pkg::ALU_SLL:  result = a << shamt;
            core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::ALU_SLTU: result = {31'b0, a < b};
            core_pkg::ALU_XOR:  result = a ^ b;
            core_pkg::ALU_SRL:  result = a >> shamt;
            core_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            core_pkg::ALU_OR:   result = a | b;
            core_pkg::ALU_AND:  result = a & b;
            default:            result = b; // pass_b
        endcase
    end

    // branch compare, only looked at for branches
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  branch_taken = (a == b);
            rv_isa_pkg::F3_BNE:  branch_taken = (a != b);
            rv_isa_pkg::F3_BLT:  branch_taken = ($signed(a) < $signed(b));
            rv_isa_pkg::F3_BGE:  branch_taken = ($signed(a) >= $signed(b));
            rv_isa_pkg::F3_BLTU: branch_taken = (a < b);
            rv_isa_pkg::F3_BGEU: branch_taken = (a >= b);
            default:             branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  core_pkg::word_t inst,
    output core_pkg::ctrl_t ctrl
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // alt selects sub / sra
    function automatic core_pkg::alu_op_t alu_op_from(
        input rv_isa_pkg::funct3_t f3,
        input logic                alt
    );
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     return core_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     return core_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    return core_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     return core_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:      return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      return core_pkg::ALU_OR;
            default:                return core_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl        = '0;               // no writes, acts as a bubble
        ctrl.alu_op = core_pkg::ALU_PASS_B;
        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                ctrl.alu_op    = core_pkg::ALU_ADD;
                ctrl.op_a_sel  = core_pkg::OPA_ZERO; // 0 + imm
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl.alu_op    = core_pkg::ALU_ADD;
                ctrl.op_a_sel  = core_pkg::OPA_PC;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::WB_PC_PLUS4;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.alu_op    = core_pkg::ALU_ADD; // target from the alu
                ctrl.use_imm   = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::WB_PC_PLUS4;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl.alu_op = core_pkg::ALU_SUB;
                ctrl.branch = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.alu_op    = core_pkg::ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::WB_MEM;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.alu_op    = core_pkg::ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // bit 30 is part of the immediate except for shifts
                ctrl.alu_op    = alu_op_from(funct3, inst[30] && funct3 == rv_isa_pkg::F3_SR);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP: begin
                ctrl.alu_op    = alu_op_from(funct3, inst[30]);
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                // ecall, ebreak and csr ops are not supported, run as nop
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  core_pkg::word_t inst,
    output core_pkg::word_t imm
);

    rv_isa_pkg::opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_JALR:
                imm = {{20{inst[31]}}, inst[31:20]};                              // I
            rv_isa_pkg::OPC_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};                  // S
            rv_isa_pkg::OPC_BRANCH:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:
                imm = {inst[31:12], 12'b0};                                       // U
            rv_isa_pkg::OPC_JAL:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0; // R-type and unknown
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_isa_pkg::reg_addr_t ra1,
    input  rv_isa_pkg::reg_addr_t ra2,
    output core_pkg::word_t       rd1,
    output core_pkg::word_t       rd2,
    input  logic                  we,
    input  rv_isa_pkg::reg_addr_t wa,
    input  core_pkg::word_t       wd
);

    core_pkg::word_t regs [32];
    logic            wr_live;

    assign wr_live = we && (wa != '0); // x0 stays zero

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wa] <= wd;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* hdl/sync_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_ram #(
    parameter int AWIDTH = 10
) (
    input  logic              clk,
    input  logic [AWIDTH-1:0] addr,
    input  core_pkg::word_t   wdata,
    input  logic [3:0]        be,
    output core_pkg::word_t   rdata
);

    localparam int DEPTH = 1 << AWIDTH;

    core_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
        rdata <= mem[addr]; // read returns the old word on a write
    end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} wb_sel_t;

    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        op_a_sel_t op_a_sel;
        logic      use_imm;   // operand b from immediate
        logic      reg_write;
        logic      mem_write;
        logic      mem_read;
        logic      branch;
        logic      jump;      // jal and jalr
        logic      jalr;
        wb_sel_t   wb_sel;
    } ctrl_t;

    // decode -> execute
    typedef struct packed {
        logic                  valid;
        word_t                 pc;
        word_t                 rs1_data;
        word_t                 rs2_data;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        word_t                 imm;
        rv_isa_pkg::funct3_t   funct3;
        ctrl_t                 ctrl;
    } ex_reg_t;

    // execute -> write-back
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_write;
        wb_sel_t               wb_sel;
        word_t                 alu_result;
        word_t                 pc_plus4;
    } wb_reg_t;

    localparam word_t CSR_ADDR = 32'h8000_0010; // memory mapped csr output

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // instruction field widths
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int REG_ADDR_W = 5;

    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // base opcodes, RV32I
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_ADD_SUB = 3'b000; // sub only for OP with bit 30
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101; // srl / sra by bit 30
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

endpackage

`default_nettype wire
